/* verilog/boot_pkg.sv */
package boot_pkg;

  // one 32-bit instruction per iccm location
  localparam int unsigned ICCM_ADDR_W = 8;
  localparam int unsigned ICCM_DEPTH  = 2 ** ICCM_ADDR_W;

  // uart bit timing in system clocks
  // kept short so a simulated frame stays cheap
  localparam int unsigned CLKS_PER_BIT = 8;
  localparam int unsigned BIT_CNT_W    = $clog2(CLKS_PER_BIT);

  // received serial byte
  typedef logic [7:0] byte_t;

  // instruction word as stored in the iccm
  typedef logic [31:0] word_t;

  // iccm word address
  typedef logic [ICCM_ADDR_W-1:0] iccm_addr_t;

  // clocks counted inside one uart bit
  typedef logic [BIT_CNT_W-1:0] bit_cnt_t;

  // reserved word that ends the program stream
  localparam word_t END_MARKER = 32'h0000_0FFF;

  // loader control states
  typedef enum logic [1:0] {
    LOAD_IDLE  = 2'd0,
    LOAD_WRITE = 2'd1,
    LOAD_DONE  = 2'd2
  } load_state_e;

endpackage

/* verilog/pack_if.sv */
interface pack_if;
  import boot_pkg::*;

  // byte side, fed from the uart receiver
  logic  byte_dv;
  byte_t rx_byte;

  // word side, assembled by the packer
  logic  word_dv;
  word_t word;

  // controller tells the packer to drop partial words
  logic  clear;

  modport packer (
    input  byte_dv,
    input  rx_byte,
    input  clear,
    output word_dv,
    output word
  );

  modport ctrl (
    input  word_dv,
    input  word,
    output clear
  );

  modport source (
    output byte_dv,
    output rx_byte
  );

endinterface

/* verilog/uart_rx.sv */
module uart_rx (
  input  logic            clock,
  input  logic            rst_n_i,
  input  logic            rx_serial_i,
  output logic            rx_dv_o,
  output boot_pkg::byte_t rx_byte_o
);
  import boot_pkg::*;

  typedef enum logic [1:0] {
    RX_IDLE  = 2'd0,
    RX_START = 2'd1,
    RX_DATA  = 2'd2,
    RX_STOP  = 2'd3
  } rx_state_e;

  rx_state_e  state_q;
  logic       rx_meta_q;
  logic       rx_sync_q;
  bit_cnt_t   clk_cnt_q;
  logic [2:0] bit_idx_q;
  byte_t      shift_q;
  logic       dv_q;
  logic       bit_end;
  logic       half_bit;

  // sample points inside a bit period
  assign bit_end  = (clk_cnt_q == BIT_CNT_W'(CLKS_PER_BIT - 1));
  assign half_bit = (clk_cnt_q == BIT_CNT_W'(CLKS_PER_BIT / 2 - 1));

  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      // idle line is high
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
      state_q   <= RX_IDLE;
      clk_cnt_q <= '0;
      bit_idx_q <= '0;
      dv_q      <= 1'b0;
    end else begin
      rx_meta_q <= rx_serial_i;
      rx_sync_q <= rx_meta_q;
      dv_q      <= 1'b0;
      case (state_q)
        RX_IDLE: begin
          clk_cnt_q <= '0;
          bit_idx_q <= '0;
          if (!rx_sync_q) begin
            state_q <= RX_START;
          end
        end
        RX_START: begin
          if (half_bit) begin
            clk_cnt_q <= '0;
            // a high line here was only a glitch
            state_q   <= rx_sync_q ? RX_IDLE : RX_DATA;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        RX_DATA: begin
          if (bit_end) begin
            clk_cnt_q <= '0;
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == 3'd7) begin
              state_q <= RX_STOP;
            end
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        RX_STOP: begin
          if (bit_end) begin
            clk_cnt_q <= '0;
            // a low stop bit drops the byte as a framing error
            dv_q      <= rx_sync_q;
            state_q   <= RX_IDLE;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // lsb arrives first so bits shift in from the top
  always_ff @(posedge clock) begin
    if (state_q == RX_DATA && bit_end) begin
      shift_q <= {rx_sync_q, shift_q[7:1]};
    end
  end

  assign rx_dv_o   = dv_q;
  assign rx_byte_o = shift_q;

  // a frame is far longer than one clock
  a_dv_single: assert property (@(posedge clock) disable iff (!rst_n_i)
    rx_dv_o |=> !rx_dv_o);

endmodule

/* verilog/word_packer.sv */
module word_packer (
  input logic    clock,
  input logic    rst_n_i,
  pack_if.packer pk
);
  import boot_pkg::*;

  logic [1:0] byte_cnt_q;
  word_t      word_q;
  logic       word_dv_q;
  logic       take_byte;

  // bytes are ignored while the controller holds clear
  assign take_byte = pk.byte_dv && !pk.clear;

  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      byte_cnt_q <= '0;
      word_dv_q  <= 1'b0;
    end else begin
      word_dv_q <= take_byte && (byte_cnt_q == 2'd3);
      if (pk.clear) begin
        byte_cnt_q <= '0;
      end else if (take_byte) begin
        byte_cnt_q <= byte_cnt_q + 1'b1;
      end
    end
  end

  // first byte lands in bits 7:0
  always_ff @(posedge clock) begin
    if (take_byte) begin
      word_q[{byte_cnt_q, 3'b000} +: 8] <= pk.rx_byte;
    end
  end

  assign pk.word_dv = word_dv_q;
  assign pk.word    = word_q;

  // every word completes on a byte from the receiver
  a_word_after_byte: assert property (@(posedge clock) disable iff (!rst_n_i)
    pk.word_dv |-> $past(pk.byte_dv));

endmodule

/* verilog/iccm_ctrl.sv */
module iccm_ctrl (
  input  logic                 clock,
  input  logic                 rst_n_i,
  pack_if.ctrl                 pk,
  output logic                 wr_en_o,
  output boot_pkg::iccm_addr_t wr_addr_o,
  output boot_pkg::word_t      wr_data_o,
  output logic                 core_rst_n_o
);
  import boot_pkg::*;

  load_state_e state_q;
  load_state_e state_d;
  iccm_addr_t  addr_q;
  word_t       data_q;
  logic        wr_en_q;
  logic        core_rst_n_q;
  logic        is_marker;

  assign is_marker = (pk.word == END_MARKER);

  always_comb begin
    state_d = state_q;
    case (state_q)
      LOAD_IDLE: begin
        if (pk.word_dv) begin
          state_d = is_marker ? LOAD_DONE : LOAD_WRITE;
        end
      end
      LOAD_WRITE: begin
        // memory is full after the last location
        if (addr_q == '1) begin
          state_d = LOAD_DONE;
        end else begin
          state_d = LOAD_IDLE;
        end
      end
      LOAD_DONE: state_d = LOAD_DONE;
      default:   state_d = LOAD_IDLE;
    endcase
  end

  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      state_q      <= LOAD_IDLE;
      addr_q       <= '0;
      wr_en_q      <= 1'b0;
      core_rst_n_q <= 1'b0;
    end else begin
      state_q <= state_d;
      wr_en_q <= (state_d == LOAD_WRITE);
      if (state_q == LOAD_WRITE) begin
        addr_q <= addr_q + 1'b1;
      end
      // core leaves reset once loading is over
      if (state_d == LOAD_DONE) begin
        core_rst_n_q <= 1'b1;
      end
    end
  end

  // word held for the write cycle
  always_ff @(posedge clock) begin
    if (state_q == LOAD_IDLE && pk.word_dv) begin
      data_q <= pk.word;
    end
  end

  assign pk.clear     = (state_q == LOAD_DONE);
  assign wr_en_o      = wr_en_q;
  assign wr_addr_o    = addr_q;
  assign wr_data_o    = data_q;
  assign core_rst_n_o = core_rst_n_q;

  // no iccm writes once the core may be fetching
  a_no_write_done: assert property (@(posedge clock) disable iff (!rst_n_i)
    (state_q == LOAD_DONE) |-> !wr_en_o);

  // core reset is only reapplied by a system reset
  a_core_rst_hold: assert property (@(posedge clock) disable iff (!rst_n_i)
    core_rst_n_o |=> core_rst_n_o);

endmodule

/* verilog/iccm_mem.sv */
module iccm_mem (
  input  logic                 clock,
  input  logic                 wr_en_i,
  input  boot_pkg::iccm_addr_t wr_addr_i,
  input  boot_pkg::word_t      wr_data_i,
  input  logic                 rst_n_i,
  input  logic                 fetch_req_i,
  input  boot_pkg::iccm_addr_t fetch_addr_i,
  output boot_pkg::word_t      fetch_rdata_o,
  output logic                 fetch_valid_o
);
  import boot_pkg::*;

  word_t mem_q [ICCM_DEPTH];
  word_t rdata_q;
  logic  valid_q;

  // load port from the controller
  always_ff @(posedge clock) begin
    if (wr_en_i) begin
      mem_q[wr_addr_i] <= wr_data_i;
    end
  end

  // registered fetch read
  always_ff @(posedge clock) begin
    if (fetch_req_i) begin
      rdata_q <= mem_q[fetch_addr_i];
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= fetch_req_i;
    end
  end

  assign fetch_rdata_o = rdata_q;
  assign fetch_valid_o = valid_q;

endmodule

/* verilog/boot_loader_top.sv */
module boot_loader_top (
  input  logic                 clock,
  input  logic                 rst_n_i,
  input  logic                 uart_rx_i,
  input  logic                 fetch_req_i,
  input  boot_pkg::iccm_addr_t fetch_addr_i,
  output boot_pkg::word_t      fetch_rdata_o,
  output logic                 fetch_valid_o,
  output logic                 core_rst_n_o
);
  import boot_pkg::*;

  logic       iccm_wr_en;
  iccm_addr_t iccm_wr_addr;
  word_t      iccm_wr_data;

  pack_if pk ();

  // serial programming port
  uart_rx u_uart_rx (
    .clock       (clock),
    .rst_n_i     (rst_n_i),
    .rx_serial_i (uart_rx_i),
    .rx_dv_o     (pk.byte_dv),
    .rx_byte_o   (pk.rx_byte)
  );

  word_packer u_word_packer (
    .clock   (clock),
    .rst_n_i (rst_n_i),
    .pk      (pk.packer)
  );

  // load sequencing and core reset
  iccm_ctrl u_iccm_ctrl (
    .clock        (clock),
    .rst_n_i      (rst_n_i),
    .pk           (pk.ctrl),
    .wr_en_o      (iccm_wr_en),
    .wr_addr_o    (iccm_wr_addr),
    .wr_data_o    (iccm_wr_data),
    .core_rst_n_o (core_rst_n_o)
  );

  iccm_mem u_iccm_mem (
    .clock         (clock),
    .wr_en_i       (iccm_wr_en),
    .wr_addr_i     (iccm_wr_addr),
    .wr_data_i     (iccm_wr_data),
    .rst_n_i       (rst_n_i),
    .fetch_req_i   (fetch_req_i),
    .fetch_addr_i  (fetch_addr_i),
    .fetch_rdata_o (fetch_rdata_o),
    .fetch_valid_o (fetch_valid_o)
  );

endmodule

/* verif/tb_boot_loader.sv */
module tb_boot_loader;
  import boot_pkg::*;

  localparam int unsigned NUM_WORDS  = 6;
  localparam int unsigned SEED       = 29911;
  localparam int unsigned WAIT_LIMIT = 400;

  logic       clock;
  logic       rst_n_i;
  logic       uart_rx_i;
  logic       fetch_req_i;
  iccm_addr_t fetch_addr_i;
  word_t      fetch_rdata_o;
  logic       fetch_valid_o;
  logic       core_rst_n_o;

  word_t ref_words [NUM_WORDS];
  word_t spare_word;
  word_t addr6_before;
  word_t rd_word;
  logic  loading;

  boot_loader_top i_boot_loader_top (
    .clock         (clock),
    .rst_n_i       (rst_n_i),
    .uart_rx_i     (uart_rx_i),
    .fetch_req_i   (fetch_req_i),
    .fetch_addr_i  (fetch_addr_i),
    .fetch_rdata_o (fetch_rdata_o),
    .fetch_valid_o (fetch_valid_o),
    .core_rst_n_o  (core_rst_n_o)
  );

  always #20 clock = ~clock;

  task automatic abort_run(input string why);
    $display("TB FAILED");
    $display("%s", why);
    $fatal(1, "stopping at first error");
  endtask

  // one uart bit held for a bit time from a falling edge
  task automatic drive_bit(input logic value);
    @(negedge clock);
    uart_rx_i = value;
    repeat (CLKS_PER_BIT - 1) @(negedge clock);
  endtask

  // start, eight data bits lsb first, stop, then idle time
  task automatic send_byte(input byte_t data, input logic bad_stop);
    drive_bit(1'b0);
    for (int i = 0; i < 8; i++) begin
      drive_bit(data[i]);
    end
    drive_bit(!bad_stop);
    drive_bit(1'b1);
  endtask

  task automatic send_word(input word_t w);
    for (int i = 0; i < 4; i++) begin
      send_byte(w[8*i +: 8], 1'b0);
    end
  endtask

  task automatic fetch_word(input int unsigned addr, output word_t data);
    int unsigned cycles;
    cycles = 0;
    @(negedge clock);
    fetch_req_i  = 1'b1;
    fetch_addr_i = iccm_addr_t'(addr);
    @(negedge clock);
    fetch_req_i = 1'b0;
    while (!fetch_valid_o && cycles < WAIT_LIMIT) begin
      @(negedge clock);
      cycles++;
    end
    if (!fetch_valid_o) begin
      abort_run("timeout waiting for fetch_valid_o");
    end else begin
      data = fetch_rdata_o;
    end
  endtask

  task automatic check_word(input int unsigned addr, input word_t expected);
    word_t got;
    fetch_word(addr, got);
    assert (got === expected) else
      abort_run($sformatf("mismatch fetch_rdata_o addr %0d expected %08h actual %08h",
                          addr, expected, got));
  endtask

  task automatic wait_core_release();
    int unsigned cycles;
    cycles = 0;
    while (!core_rst_n_o && cycles < WAIT_LIMIT) begin
      @(negedge clock);
      cycles++;
    end
    if (!core_rst_n_o) begin
      abort_run("timeout waiting for core_rst_n_o to rise");
    end
  endtask

  // valid only in the cycle right after a request
  a_fetch_valid: assert property (@(posedge clock) disable iff (!rst_n_i)
    fetch_valid_o == $past(fetch_req_i))
    else begin
      $display("TB FAILED");
      $display("fetch_valid_o does not follow fetch_req_i by exactly one cycle");
      $fatal(1, "stopping at first error");
    end

  a_core_held: assert property (@(posedge clock) disable iff (!rst_n_i)
    loading |-> !core_rst_n_o)
    else begin
      $display("TB FAILED");
      $display("core_rst_n_o released before the end marker was sent");
      $fatal(1, "stopping at first error");
    end

  a_core_stays: assert property (@(posedge clock) disable iff (!rst_n_i)
    core_rst_n_o |=> core_rst_n_o)
    else begin
      $display("TB FAILED");
      $display("core_rst_n_o fell again after it was released");
      $fatal(1, "stopping at first error");
    end

  initial begin
    clock        = 1'b0;
    rst_n_i      = 1'b0;
    uart_rx_i    = 1'b1;
    fetch_req_i  = 1'b0;
    fetch_addr_i = '0;
    loading      = 1'b0;

    void'($urandom(SEED));
    for (int k = 0; k < NUM_WORDS; k++) begin
      ref_words[k] = $urandom();
      while (ref_words[k] == END_MARKER) begin
        ref_words[k] = $urandom();
      end
    end

    repeat (2) @(posedge clock);
    @(negedge clock);
    rst_n_i = 1'b1;
    assert (core_rst_n_o === 1'b0) else
      abort_run($sformatf("mismatch core_rst_n_o expected %h actual %h",
                          1'b0, core_rst_n_o));
    loading = 1'b1;

    // a dropped frame before word 2 must not shift the packing
    send_word(ref_words[0]);
    send_word(ref_words[1]);
    send_byte(8'hA5, 1'b1);
    for (int k = 2; k < NUM_WORDS; k++) begin
      send_word(ref_words[k]);
    end

    loading = 1'b0;
    send_word(END_MARKER);
    wait_core_release();

    for (int k = 0; k < NUM_WORDS; k++) begin
      check_word(k, ref_words[k]);
    end

    // traffic after the marker must not reach the iccm
    fetch_word(NUM_WORDS, addr6_before);
    spare_word = $urandom();
    while (spare_word == END_MARKER) begin
      spare_word = $urandom();
    end
    send_word(spare_word);

    for (int k = 0; k < NUM_WORDS; k++) begin
      check_word(k, ref_words[k]);
    end
    fetch_word(NUM_WORDS, rd_word);
    assert (rd_word === addr6_before) else
      abort_run($sformatf("mismatch fetch_rdata_o addr %0d expected %08h actual %08h",
                          NUM_WORDS, addr6_before, rd_word));

    repeat (4) @(negedge clock);
    $display("TB PASSED");
    $finish;
  end

endmodule

/* verilog.f */
verilog/boot_pkg.sv
verilog/pack_if.sv
verilog/uart_rx.sv
verilog/word_packer.sv
verilog/iccm_ctrl.sv
verilog/iccm_mem.sv
verilog/boot_loader_top.sv
verif/tb_boot_loader.sv

/* Makefile */
TOP := tb_boot_loader

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): verilog.f $(shell cat verilog.f)
	verilator --binary --timing --assert -j 0 -f verilog.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TB PASSED"

lint:
	verilator --lint-only -Wall --timing -f verilog.f --top-module boot_loader_top

clean:
	rm -rf obj_dir
